/* source/game_pkg.sv */
/*
 * game package
 * controller states, handshake event codes, the pulse/control/status bundles
 * and the enemy mix of each stage
 */
`default_nettype none

package game_pkg;

	typedef enum logic [2:0] {
		GS_RESET     = 3'd0,
		GS_RUN       = 3'd1,
		GS_PAUSE     = 3'd2,
		GS_STAGE_WON = 3'd3,
		GS_GAME_OVER = 3'd4
	} game_state_e;

	// code carried on the sprite event handshake
	typedef enum logic [1:0] {
		EV_NONE        = 2'd0,
		EV_WIN_STAGE   = 2'd1,
		EV_PLAYER_DEAD = 2'd2,
		EV_SKIP_STAGE  = 2'd3
	} game_event_e;

	typedef struct packed {
		logic win_stage;
		logic player_dead;
		logic skip_stage;
	} game_events_t; // one-cycle pulses

	typedef struct packed {
		logic enable_player;
		logic enable_monst;
		logic enable_boss;
		logic enable_astero;
		logic resetN_player; // active low
		logic resetN_monst;  // active low
	} play_ctrl_t;

	typedef struct packed {
		game_state_e mode;
		logic [2:0]  stage_num;
		logic        game_won;
		logic        game_over;
	} game_status_t;

	localparam int NUM_STAGES = 5;
	localparam logic [2:0] LAST_STAGE = 3'd4;

	// enemy mix, bit i set when stage i has that kind
	localparam logic [NUM_STAGES-1:0] STAGE_MONST  = 5'b01011; // stages 0,1,3
	localparam logic [NUM_STAGES-1:0] STAGE_ASTERO = 5'b01100; // stages 2,3
	localparam logic [NUM_STAGES-1:0] STAGE_BOSS   = 5'b10000; // final stage

endpackage

`default_nettype wire

/* source/event_decoder.sv */
/*
 * event decoder
 * four-phase req/ack receiver for sprite block events, gives one
 * pulse per handshake on the acknowledge edge
 */
`timescale 1ns/1ps
`default_nettype none

module event_decoder (
	input  logic                  clk,
	input  logic                  resetN,
	input  logic                  ev_req,
	input  game_pkg::game_event_e ev_code,
	output logic                  ev_ack,
	output game_pkg::game_events_t events
);
	import game_pkg::*;

	game_events_t decoded;
	logic         accept;

	assign accept = ev_req && !ev_ack; // new request, not yet acked

	// code is held stable by the sender while req is high
	always_comb begin
		decoded = '0;
		case (ev_code)
			EV_WIN_STAGE:   decoded.win_stage   = 1'b1;
			EV_PLAYER_DEAD: decoded.player_dead = 1'b1;
			EV_SKIP_STAGE:  decoded.skip_stage  = 1'b1;
			default:        decoded = '0; // EV_NONE is acked silently
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ev_ack <= 1'b0;
			events <= '0;
		end else begin
			if (accept) begin
				ev_ack <= 1'b1;
				events <= decoded;
			end else begin
				events <= '0; // pulse lasts a single cycle
				if (!ev_req)
					ev_ack <= 1'b0; // sender released, close the handshake
			end
		end
	end

endmodule

`default_nettype wire

/* source/stage_controller.sv */
/*
 * stage controller
 * counts the five stages, flags the win after the last one and looks up
 * which enemy kinds take part in the current stage
 */
`timescale 1ns/1ps
`default_nettype none

module stage_controller (
	input  logic       clk,
	input  logic       resetN,
	input  logic       restart,
	input  logic       stage_advance,
	output logic [2:0] stage_num,
	output logic       enable_monst,
	output logic       enable_boss,
	output logic       enable_astero,
	output logic       game_won
);
	import game_pkg::*;

	logic at_last;

	assign at_last = (stage_num == LAST_STAGE);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			stage_num <= 3'd0;
			game_won  <= 1'b0;
		end else if (restart) begin
			stage_num <= 3'd0;
			game_won  <= 1'b0;
		end else if (stage_advance) begin
			if (at_last)
				game_won <= 1'b1; // stays on stage 4
			else
				stage_num <= stage_num + 3'd1;
		end
	end

	// enemy kinds of this stage, gated by state in the controller
	always_comb begin
		enable_monst  = STAGE_MONST[stage_num];
		enable_boss   = STAGE_BOSS[stage_num];
		enable_astero = STAGE_ASTERO[stage_num];
	end

endmodule

`default_nettype wire

/* source/game_controller.sv */
/*
 * game controller
 * top level game FSM, runs, pauses, advances stages and ends the game,
 * drives the sprite enables and their local resets
 */
`timescale 1ns/1ps
`default_nettype none

module game_controller (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_game,
	input  logic                   pause,
	input  game_pkg::game_events_t events,
	output game_pkg::play_ctrl_t   play,
	output game_pkg::game_status_t status
);
	import game_pkg::*;

	game_state_e state;
	game_state_e next_state;

	logic       stage_advance;
	logic       restart;
	logic [2:0] stage_num;
	logic       mix_monst;
	logic       mix_boss;
	logic       mix_astero;
	logic       game_won;
	logic       stage_done;

	assign stage_done = events.win_stage || events.skip_stage;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			state <= GS_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state    = state;
		stage_advance = 1'b0;
		case (state)
			GS_RESET: begin
				if (start_game)
					next_state = GS_RUN;
			end
			GS_RUN: begin
				if (!start_game)
					next_state = GS_RESET;
				else if (pause)
					next_state = GS_PAUSE;
				else if (events.player_dead)
					next_state = GS_GAME_OVER;
				else if (stage_done) begin
					next_state    = GS_STAGE_WON;
					stage_advance = 1'b1;
				end
			end
			GS_PAUSE: begin
				if (!start_game)
					next_state = GS_RESET;
				else if (!pause)
					next_state = GS_RUN;
			end
			GS_STAGE_WON: next_state = game_won ? GS_GAME_OVER : GS_RUN; // single cycle
			GS_GAME_OVER: begin
				if (!start_game)
					next_state = GS_RESET;
			end
			default: next_state = GS_RESET;
		endcase
	end

	assign restart = (state == GS_RESET); // holds stage counter at 0

	// play bundle from state and this stage's enemy mix
	always_comb begin
		play = '0; // enables off
		play.resetN_player = (state != GS_RESET);
		play.resetN_monst  = (state != GS_RESET) && (state != GS_STAGE_WON);
		if (state == GS_RUN) begin
			play.enable_player = 1'b1;
			play.enable_monst  = mix_monst;
			play.enable_boss   = mix_boss;
			play.enable_astero = mix_astero;
		end else if (state == GS_STAGE_WON) begin
			play.enable_player = 1'b1;
		end
	end

	assign status.mode      = state;
	assign status.stage_num = stage_num;
	assign status.game_won  = game_won;
	assign status.game_over = (state == GS_GAME_OVER) && !game_won;

	stage_controller stage_controller_i (
		.clk           (clk),
		.resetN        (resetN),
		.restart       (restart),
		.stage_advance (stage_advance),
		.stage_num     (stage_num),
		.enable_monst  (mix_monst),
		.enable_boss   (mix_boss),
		.enable_astero (mix_astero),
		.game_won      (game_won)
	);

endmodule

`default_nettype wire

/* source/game_top.sv */
/*
 * game top level
 * sprite event handshake receiver feeding the game controller
 */
`timescale 1ns/1ps
`default_nettype none

module game_top (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_game, // level switch
	input  logic                   pause,      // level switch
	input  logic                   ev_req,
	input  game_pkg::game_event_e  ev_code,
	output logic                   ev_ack,
	output game_pkg::play_ctrl_t   play,
	output game_pkg::game_status_t status
);
	import game_pkg::*;

	game_events_t events; // decoded pulses

	event_decoder event_decoder_i (
		.clk     (clk),
		.resetN  (resetN),
		.ev_req  (ev_req),
		.ev_code (ev_code),
		.ev_ack  (ev_ack),
		.events  (events)
	);

	game_controller game_controller_i (
		.clk        (clk),
		.resetN     (resetN),
		.start_game (start_game),
		.pause      (pause),
		.events     (events),
		.play       (play),
		.status     (status)
	);

endmodule

`default_nettype wire

/* tests/game_tb.sv */
/*
 * game testbench
 * replays the steps of the test data file on the game top level and checks
 * mode, stage, result flags, play bundle and handshake after each step
 */
`timescale 1ns/1ps
`default_nettype none

module game_tb;
	import game_pkg::*;

	localparam int HS_TIMEOUT = 20; // cycles allowed per handshake phase

	logic         clk;
	logic         resetN;
	logic         start_game;
	logic         pause;
	logic         ev_req;
	game_event_e  ev_code;
	logic         ev_ack;
	play_ctrl_t   play;
	game_status_t status;

	int    errors;
	int    checks;
	int    tests_run;
	int    tests_failed;
	int    test_errors;
	int    test_steps;
	string cur_test;

	game_top game_top_i (
		.clk        (clk),
		.resetN     (resetN),
		.start_game (start_game),
		.pause      (pause),
		.ev_req     (ev_req),
		.ev_code    (ev_code),
		.ev_ack     (ev_ack),
		.play       (play),
		.status     (status)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_field(input string test, input string field,
			input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
				test, field, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		errors++;
		test_errors++;
	endtask

	// mode names in the data file
	function automatic int mode_value(input string name);
		if (name == "RESET") return int'(GS_RESET);
		if (name == "RUN") return int'(GS_RUN);
		if (name == "PAUSE") return int'(GS_PAUSE);
		if (name == "STAGE_WON") return int'(GS_STAGE_WON);
		if (name == "GAME_OVER") return int'(GS_GAME_OVER);
		return -1;
	endfunction

	function automatic int event_value(input string name);
		if (name == "NONE") return int'(EV_NONE);
		if (name == "WIN") return int'(EV_WIN_STAGE);
		if (name == "DEAD") return int'(EV_PLAYER_DEAD);
		if (name == "SKIP") return int'(EV_SKIP_STAGE);
		return -1;
	endfunction

	// four-phase sender, one call per event
	task automatic send_event(input string test, input game_event_e code);
		int waited;
		ev_code = code; // code first, req one cycle later
		@(negedge clk);
		ev_req = 1'b1;
		waited = 0;
		while (!ev_ack && waited < HS_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!ev_ack)
			report_error($sformatf("%s: ev_ack never rose after ev_req", test));
		ev_req = 1'b0;
		waited = 0;
		while (ev_ack && waited < HS_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (ev_ack)
			report_error($sformatf("%s: ev_ack stuck high after ev_req fell", test));
		ev_code = EV_NONE;
	endtask

	task automatic close_test();
		if (cur_test != "") begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %s: passed, %0d steps", cur_test, test_steps);
			end else begin
				$display("test %s: failed, %0d errors in %0d steps",
					cur_test, test_errors, test_steps);
				tests_failed++;
			end
		end
		test_errors = 0;
		test_steps = 0;
	endtask

	task automatic run_step(input string test, input string action, input string arg,
			input string mode_name, input int exp_stage, input int exp_won,
			input int exp_over, input logic [5:0] exp_play);
		int exp_mode;
		int code;
		exp_mode = mode_value(mode_name);
		code = event_value(arg);
		if (action == "start")
			start_game = (arg.atoi() != 0);
		else if (action == "pause")
			pause = (arg.atoi() != 0);
		else if (action == "wait")
			repeat (arg.atoi()) @(negedge clk);
		else if (action == "event" && code >= 0)
			send_event(test, game_event_e'(code));
		else
			report_error({test, ": bad action or event name ", action, " ", arg});
		repeat (2) @(negedge clk); // state and stage settle
		if (exp_mode < 0)
			report_error({test, ": unknown mode name ", mode_name});
		else
			check_field(test, "mode", exp_mode, int'(status.mode));
		check_field(test, "stage_num", exp_stage, int'(status.stage_num));
		check_field(test, "game_won", exp_won, int'(status.game_won));
		check_field(test, "game_over", exp_over, int'(status.game_over));
		check_field(test, "play", int'(exp_play), int'(play));
		check_field(test, "ev_ack", 0, int'(ev_ack)); // handshake closed
	endtask

	initial begin
		int         fd;
		int         got;
		int         fields;
		string      line;
		string      name;
		string      action;
		string      arg;
		string      mode_name;
		int         exp_stage;
		int         exp_won;
		int         exp_over;
		logic [5:0] exp_play;

		resetN = 1'b0;
		start_game = 1'b0;
		pause = 1'b0;
		ev_req = 1'b0;
		ev_code = EV_NONE;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errors = 0;
		test_steps = 0;
		cur_test = "";
		repeat (16) @(negedge clk);
		resetN = 1'b1;

		fd = $fopen("tests/game_tests.txt", "r");
		if (fd == 0) begin
			report_error("cannot open tests/game_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %s %s %s %d %d %d %b", name, action, arg,
						mode_name, exp_stage, exp_won, exp_over, exp_play);
					if (fields != 8) begin
						report_error({"cannot parse test line: ", line});
					end else begin
						if (name != cur_test) begin
							close_test();
							cur_test = name;
						end
						test_steps++;
						run_step(name, action, arg, mode_name, exp_stage, exp_won,
							exp_over, exp_play);
					end
				end
			end
			$fclose(fd);
			close_test();
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_run > 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/game_tests.txt */
# columns: test action arg mode stage_num game_won game_over play
# start/pause take a level, event takes NONE/WIN/DEAD/SKIP, wait takes cycles
# play bits: player monst boss astero resetN_player resetN_monst
reset_start  wait  2    RESET     0 0 0 000000
reset_start  pause 1    RESET     0 0 0 000000
reset_start  pause 0    RESET     0 0 0 000000
reset_start  event WIN  RESET     0 0 0 000000
reset_start  start 1    RUN       0 0 0 110011
handshake    event NONE RUN       0 0 0 110011
handshake    wait  4    RUN       0 0 0 110011
pause_resume pause 1    PAUSE     0 0 0 000011
pause_resume event WIN  PAUSE     0 0 0 000011
pause_resume pause 0    RUN       0 0 0 110011
stage_seq    event WIN  RUN       1 0 0 110011
stage_seq    event SKIP RUN       2 0 0 100111
stage_seq    pause 1    PAUSE     2 0 0 000011
stage_seq    event SKIP PAUSE     2 0 0 000011
stage_seq    pause 0    RUN       2 0 0 100111
stage_seq    event WIN  RUN       3 0 0 110111
stage_seq    event NONE RUN       3 0 0 110111
stage_seq    event WIN  RUN       4 0 0 101011
win_game     event WIN  GAME_OVER 4 1 0 000011
win_game     event DEAD GAME_OVER 4 1 0 000011
win_game     start 0    RESET     0 0 0 000000
lose_restart start 1    RUN       0 0 0 110011
lose_restart event SKIP RUN       1 0 0 110011
lose_restart event DEAD GAME_OVER 1 0 1 000011
lose_restart wait  3    GAME_OVER 1 0 1 000011
lose_restart start 0    RESET     0 0 0 000000
lose_restart start 1    RUN       0 0 0 110011
run_stop     pause 1    PAUSE     0 0 0 000011
run_stop     start 0    RESET     0 0 0 000000

/* tb.f */
source/game_pkg.sv
source/event_decoder.sv
source/stage_controller.sv
source/game_controller.sv
source/game_top.sv
tests/game_tb.sv

/* run.sh */
#!/bin/sh
# build the game testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module game_tb -f tb.f -o game_sim \
	&& ./obj_dir/game_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
